/* vmul_unit.f */
+incdir+.
riscv_v_pkg.sv
riscv_v_twos_comp_sel.sv
vedic_mul_unsigned.sv
vedic_mul.sv
vmul_issue.sv
vmul_writeback.sv
vmul_unit.sv
tb_vmul_unit.sv

/* Bender.yml */
package:
  name: vmul_unit

export_include_dirs:
  - .

sources:
  - riscv_v_pkg.sv
  - riscv_v_twos_comp_sel.sv
  - vedic_mul_unsigned.sv
  - vedic_mul.sv
  - vmul_issue.sv
  - vmul_writeback.sv
  - vmul_unit.sv
  - target: test
    files:
      - tb_vmul_unit.sv

/* tb_vmul_unit.sv */
/*
 * Testbench for the two-lane SIMD multiply unit
 * LFSR stimulus, per-element reference model, timed result checker
 */

`timescale 1ns/1ps

`include "riscv_v_consts.svh"

module tb_vmul_unit
    import riscv_v_pkg::*;
;

    localparam int CLK_PERIOD    = 8;
    // Drive edge to the negedge where out_valid is seen
    localparam int LATENCY_T     = 2 * CLK_PERIOD + CLK_PERIOD / 2;
    localparam int NUM_RANDOM    = 600;
    localparam int DRAIN_TIMEOUT = 20;

    logic                      clk;
    logic                      rst_n;
    logic                      in_valid;
    mul_op_e                   op;
    osize_e                    osize;
    logic                      is_signed;
    logic [`RV_DATA_WIDTH-1:0] src_a;
    logic [`RV_DATA_WIDTH-1:0] src_b;
    logic                      out_valid;
    logic [`RV_DATA_WIDTH-1:0] result;

    logic [15:0]               lfsr_state;
    logic [`RV_DATA_WIDTH-1:0] exp_q [$];
    time                       tag_q [$];
    logic [`RV_DATA_WIDTH-1:0] mon_exp;
    time                       mon_tag;
    int                        mismatch_count;
    int                        other_count;

    vmul_unit DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .op        (op),
        .osize     (osize),
        .is_signed (is_signed),
        .src_a     (src_a),
        .src_b     (src_b),
        .out_valid (out_valid),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
    endtask

    function automatic osize_e size_from_bits(input logic [1:0] v);
        case (v)
            2'd0:    return OSIZE_8;
            2'd1:    return OSIZE_16;
            default: return OSIZE_32;
        endcase
    endfunction

    // Most negative value in every element
    function automatic logic [63:0] min_pattern(input osize_e s);
        case (s)
            OSIZE_8:  return {8{8'h80}};
            OSIZE_16: return {4{16'h8000}};
            default:  return {2{32'h8000_0000}};
        endcase
    endfunction

    // Extend each element, multiply at 64 bits, keep the chosen half
    function automatic logic [63:0] model_mul(input mul_op_e o, input osize_e s,
                                              input logic sg, input logic [63:0] a,
                                              input logic [63:0] b);
        int          w;
        logic [63:0] mask;
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] prod;
        logic [63:0] part;
        logic [63:0] res;
        case (s)
            OSIZE_8:  w = 8;
            OSIZE_16: w = 16;
            default:  w = 32;
        endcase
        mask = (64'd1 << w) - 64'd1;
        res  = '0;
        for (int e = 0; e < 64 / w; e++) begin
            ea = (a >> (e * w)) & mask;
            eb = (b >> (e * w)) & mask;
            if (sg && ea[w-1]) ea = ea | ~mask;
            if (sg && eb[w-1]) eb = eb | ~mask;
            prod = ea * eb;
            part = (o == MUL_HI) ? ((prod >> w) & mask) : (prod & mask);
            res  = res | (part << (e * w));
        end
        return res;
    endfunction

    task automatic drive_idle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic drive_op(input mul_op_e o, input osize_e s, input logic sg,
                            input logic [63:0] a, input logic [63:0] b);
        @(posedge clk);
        in_valid  <= 1'b1;
        op        <= o;
        osize     <= s;
        is_signed <= sg;
        src_a     <= a;
        src_b     <= b;
        exp_q.push_back(model_mul(o, s, sg, a, b));
        tag_q.push_back($time);
    endtask

    // Results are checked mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (out_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    other_count++;
                    $display("Result at %0t with no operation in flight", $time);
                end else begin
                    mon_exp = exp_q.pop_front();
                    mon_tag = tag_q.pop_front();
                    if ($time != mon_tag + LATENCY_T) begin
                        other_count++;
                        $display("Result at %0t for operation issued at %0t came at the wrong cycle",
                                 $time, mon_tag);
                    end
                    if (result !== mon_exp) begin
                        mismatch_count++;
                        $display("Mismatch at %0t: result expected %h got %h",
                                 $time, mon_exp, result);
                    end
                end
            end else begin
                if (out_valid !== 1'b0) begin
                    other_count++;
                    $display("out_valid is unknown at %0t", $time);
                end
                if (exp_q.size() != 0 && $time > tag_q[0] + LATENCY_T) begin
                    other_count++;
                    $display("No result at %0t for operation issued at %0t", $time, tag_q[0]);
                    void'(exp_q.pop_front());
                    void'(tag_q.pop_front());
                end
            end
        end
    end

    initial begin : stimulus
        logic [63:0] r_gap;
        logic [63:0] r_op;
        logic [63:0] r_size;
        logic [63:0] r_sgn;
        logic [63:0] r_a;
        logic [63:0] r_b;
        logic [63:0] ones;
        osize_e      s;
        int          drain_cycles;

        rst_n          = 1'b0;
        in_valid       = 1'b0;
        op             = MUL_LO;
        osize          = OSIZE_8;
        is_signed      = 1'b0;
        src_a          = '0;
        src_b          = '0;
        lfsr_state     = 16'd34140;
        mismatch_count = 0;
        other_count    = 0;
        ones           = '1;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // Idle after reset
        repeat (3) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                other_count++;
                $display("out_valid not low after reset at %0t", $time);
            end
            if (result !== '0) begin
                mismatch_count++;
                $display("Mismatch at %0t: result expected %h got %h", $time, 64'h0, result);
            end
        end

        // Corner operands, back to back over every size, op and signedness
        for (int si = 0; si < 3; si++) begin
            s = size_from_bits(si[1:0]);
            for (int oi = 0; oi < 2; oi++) begin
                for (int sg = 0; sg < 2; sg++) begin
                    drive_op(mul_op_e'(oi[0]), s, sg[0], ones, ones);
                    drive_op(mul_op_e'(oi[0]), s, sg[0], min_pattern(s), min_pattern(s));
                    drive_op(mul_op_e'(oi[0]), s, sg[0], min_pattern(s), ones);
                end
            end
        end
        drive_idle();

        // Random operations, about a quarter of the cycles left idle
        for (int i = 0; i < NUM_RANDOM; i++) begin
            take_bits(2, r_gap);
            if (r_gap[1:0] == 2'b00) begin
                drive_idle();
            end else begin
                take_bits(1, r_op);
                take_bits(2, r_size);
                take_bits(1, r_sgn);
                take_bits(64, r_a);
                take_bits(64, r_b);
                drive_op(mul_op_e'(r_op[0]), size_from_bits(r_size[1:0]), r_sgn[0], r_a, r_b);
            end
        end
        drive_idle();

        drain_cycles = 0;
        while (exp_q.size() != 0 && drain_cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            drain_cycles++;
        end
        if (exp_q.size() != 0) begin
            other_count++;
            $display("Timed out waiting for %0d outstanding results", exp_q.size());
        end
        // Stray out_valid pulses would still be caught here
        repeat (4) @(posedge clk);

        $display("Checks done: %0d mismatches, %0d other errors", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_vmul_unit

/* vmul_unit.sv */
/*
 * Two-lane SIMD integer multiply unit
 * Issue stage, vedic lanes and writeback, two-cycle latency
 */

`timescale 1ns/1ps

`include "riscv_v_consts.svh"

module vmul_unit
    import riscv_v_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  mul_op_e                   op,
    input  osize_e                    osize,
    input  logic                      is_signed,
    input  logic [`RV_DATA_WIDTH-1:0] src_a,
    input  logic [`RV_DATA_WIDTH-1:0] src_b,
    output logic                      out_valid,
    output logic [`RV_DATA_WIDTH-1:0] result
);

    logic                                             stage_valid;
    mul_op_e                                          stage_op;
    osize_e                                           stage_osize;
    logic                                             stage_signed;
    logic [`RV_NUM_LANES-1:0][`RV_LANE_WIDTH-1:0]     lane_a;
    logic [`RV_NUM_LANES-1:0][`RV_LANE_WIDTH-1:0]     lane_b;
    logic [`RV_NUM_LANES-1:0][2*`RV_LANE_WIDTH-1:0]   lane_prod;

    vmul_issue u_issue (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .op           (op),
        .osize        (osize),
        .is_signed    (is_signed),
        .src_a        (src_a),
        .src_b        (src_b),
        .stage_valid  (stage_valid),
        .stage_op     (stage_op),
        .stage_osize  (stage_osize),
        .stage_signed (stage_signed),
        .lane_a       (lane_a),
        .lane_b       (lane_b)
    );

    // Combinational lanes between the two registers
    generate
        for (genvar lane = 0; lane < `RV_NUM_LANES; lane++) begin : gen_lane
            vedic_mul u_lane (
                .a         (lane_a[lane]),
                .b         (lane_b[lane]),
                .is_signed (stage_signed),
                .osize     (stage_osize),
                .z         (lane_prod[lane])
            );
        end
    endgenerate

    vmul_writeback u_writeback (
        .clk         (clk),
        .rst_n       (rst_n),
        .stage_valid (stage_valid),
        .stage_op    (stage_op),
        .stage_osize (stage_osize),
        .lane_prod   (lane_prod),
        .out_valid   (out_valid),
        .result      (result)
    );

endmodule : vmul_unit

/* vmul_writeback.sv */
/*
 * Writeback stage of the vector multiply unit
 * Low/high half selection, packing and output register
 */

`timescale 1ns/1ps

`include "riscv_v_consts.svh"

module vmul_writeback
    import riscv_v_pkg::*;
(
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            stage_valid,
    input  mul_op_e                                         stage_op,
    input  osize_e                                          stage_osize,
    input  logic [`RV_NUM_LANES-1:0][2*`RV_LANE_WIDTH-1:0]  lane_prod,
    output logic                                            out_valid,
    output logic [`RV_DATA_WIDTH-1:0]                       result
);

    localparam int LW = `RV_LANE_WIDTH;
    localparam int BW = `RV_BYTE_WIDTH;

    logic [`RV_DATA_WIDTH-1:0] packed_res;
    int unsigned               hi_sel;

    assign hi_sel = (stage_op == MUL_HI) ? 1 : 0;

    // Pick one half of each double-width product
    always_comb begin
        packed_res = '0;
        for (int l = 0; l < `RV_NUM_LANES; l++) begin
            case (stage_osize)
                OSIZE_8: begin
                    for (int e = 0; e < LW / BW; e++) begin
                        packed_res[l*LW + e*BW +: BW] = lane_prod[l][(2*e + hi_sel)*BW +: BW];
                    end
                end
                OSIZE_16: begin
                    for (int e = 0; e < LW / (2*BW); e++) begin
                        packed_res[l*LW + e*2*BW +: 2*BW] =
                            lane_prod[l][(2*e + hi_sel)*2*BW +: 2*BW];
                    end
                end
                default: begin
                    packed_res[l*LW +: LW] = lane_prod[l][hi_sel*LW +: LW];
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= stage_valid;
            if (stage_valid) begin
                result <= packed_res;
            end
        end
    end

    a_result_known: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !$isunknown(result))
        else $error("vmul_writeback: unknown bits in result");

endmodule : vmul_writeback

/* vmul_issue.sv */
/*
 * Issue stage of the vector multiply unit
 * Registers accepted operations and splits operands into lanes
 */

`timescale 1ns/1ps

`include "riscv_v_consts.svh"

module vmul_issue
    import riscv_v_pkg::*;
(
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          in_valid,
    input  mul_op_e                                       op,
    input  osize_e                                        osize,
    input  logic                                          is_signed,
    input  logic [`RV_DATA_WIDTH-1:0]                     src_a,
    input  logic [`RV_DATA_WIDTH-1:0]                     src_b,
    output logic                                          stage_valid,
    output mul_op_e                                       stage_op,
    output osize_e                                        stage_osize,
    output logic                                          stage_signed,
    output logic [`RV_NUM_LANES-1:0][`RV_LANE_WIDTH-1:0]  lane_a,
    output logic [`RV_NUM_LANES-1:0][`RV_LANE_WIDTH-1:0]  lane_b
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= in_valid;
        end
    end

    // Operation fields, held while idle
    always_ff @(posedge clk) begin
        if (in_valid) begin
            stage_op     <= op;
            stage_osize  <= osize;
            stage_signed <= is_signed;
            lane_a       <= src_a;
            lane_b       <= src_b;
        end
    end

    // Lanes only decode the three legal element sizes
    a_osize_legal: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> (osize inside {OSIZE_8, OSIZE_16, OSIZE_32}))
        else $error("vmul_issue: illegal osize %0d on issue", osize);

endmodule : vmul_issue

/* vedic_mul.sv */
/*
 * Signed/unsigned lane multiplier
 * Sign extraction, source and result complement, unsigned vedic tree
 */

`timescale 1ns/1ps

`include "riscv_v_consts.svh"

module vedic_mul
    import riscv_v_pkg::*;
(
    input  logic [`RV_LANE_WIDTH-1:0]   a,
    input  logic [`RV_LANE_WIDTH-1:0]   b,
    input  logic                        is_signed,
    input  osize_e                      osize,
    output logic [2*`RV_LANE_WIDTH-1:0] z
);

    localparam int NUM_BYTES = `RV_LANE_WIDTH / `RV_BYTE_WIDTH;
    localparam int BW        = `RV_BYTE_WIDTH;

    logic [NUM_BYTES-1:0]          a_sign;
    logic [NUM_BYTES-1:0]          b_sign;
    logic [NUM_BYTES-1:0]          a_comp;
    logic [NUM_BYTES-1:0]          b_comp;
    logic [NUM_BYTES-1:0]          result_comp;
    logic [`RV_LANE_WIDTH-1:0]     mag_a;
    logic [`RV_LANE_WIDTH-1:0]     mag_b;
    logic [2*`RV_LANE_WIDTH-1:0]   mag_prod;

    // Sign bit of each element, placed at its lowest byte
    always_comb begin
        a_sign = '0;
        b_sign = '0;
        case (osize)
            OSIZE_8: begin
                for (int i = 0; i < NUM_BYTES; i++) begin
                    a_sign[i] = a[BW*i + BW - 1];
                    b_sign[i] = b[BW*i + BW - 1];
                end
            end
            OSIZE_16: begin
                for (int i = 0; i < NUM_BYTES / 2; i++) begin
                    a_sign[2*i] = a[2*BW*i + 2*BW - 1];
                    b_sign[2*i] = b[2*BW*i + 2*BW - 1];
                end
            end
            default: begin
                a_sign[0] = a[`RV_LANE_WIDTH-1];
                b_sign[0] = b[`RV_LANE_WIDTH-1];
            end
        endcase
    end

    assign a_comp      = {NUM_BYTES{is_signed}} & a_sign;
    assign b_comp      = {NUM_BYTES{is_signed}} & b_sign;
    // Negative product only when the signs differ
    assign result_comp = a_comp ^ b_comp;

    riscv_v_twos_comp_sel #(
        .BLOCK_WIDTH(BW)
    ) u_comp_a (
        .in         (a),
        .complement (a_comp),
        .osize      (osize),
        .out        (mag_a)
    );

    riscv_v_twos_comp_sel #(
        .BLOCK_WIDTH(BW)
    ) u_comp_b (
        .in         (b),
        .complement (b_comp),
        .osize      (osize),
        .out        (mag_b)
    );

    vedic_mul_unsigned #(
        .WIDTH(`RV_LANE_WIDTH)
    ) u_mul (
        .a     (mag_a),
        .b     (mag_b),
        .osize (osize),
        .z     (mag_prod)
    );

    // Products sit at twice the element offset, so blocks are two bytes wide
    riscv_v_twos_comp_sel #(
        .BLOCK_WIDTH(2*BW)
    ) u_comp_result (
        .in         (mag_prod),
        .complement (result_comp),
        .osize      (osize),
        .out        (z)
    );

endmodule : vedic_mul

/* vedic_mul_unsigned.sv */
/*
 * Recursive unsigned vedic multiplier
 * Cross products masked so each element keeps its own product slot
 */

`timescale 1ns/1ps

`include "riscv_v_consts.svh"

module vedic_mul_unsigned
    import riscv_v_pkg::*;
#(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0]   a,
    input  logic [WIDTH-1:0]   b,
    input  osize_e             osize,
    output logic [2*WIDTH-1:0] z
);

    if ((WIDTH < `RV_MIN_VEDIC_WIDTH) || ((WIDTH & (WIDTH - 1)) != 0)) begin : gen_bad_width
        $fatal(1, "vedic_mul_unsigned: WIDTH must be a power of two, got %0d", WIDTH);
    end

    generate
        if (WIDTH <= `RV_MIN_VEDIC_WIDTH) begin : gen_leaf
            // Small enough to multiply directly
            assign z = a * b;
        end else begin : gen_tree
            localparam int HALF = WIDTH / 2;

            logic [WIDTH-1:0]   prod_ll;
            logic [WIDTH-1:0]   prod_lh;
            logic [WIDTH-1:0]   prod_hl;
            logic [WIDTH-1:0]   prod_hh;
            logic [WIDTH-1:0]   cross_lh;
            logic [WIDTH-1:0]   cross_hl;
            logic [2*WIDTH-1:0] cross_sum;
            int unsigned        elem_bits;
            logic               cross_en;

            vedic_mul_unsigned #(
                .WIDTH(HALF)
            ) u_mul_ll (
                .a     (a[HALF-1:0]),
                .b     (b[HALF-1:0]),
                .osize (osize),
                .z     (prod_ll)
            );

            vedic_mul_unsigned #(
                .WIDTH(HALF)
            ) u_mul_lh (
                .a     (a[HALF-1:0]),
                .b     (b[WIDTH-1:HALF]),
                .osize (osize),
                .z     (prod_lh)
            );

            vedic_mul_unsigned #(
                .WIDTH(HALF)
            ) u_mul_hl (
                .a     (a[WIDTH-1:HALF]),
                .b     (b[HALF-1:0]),
                .osize (osize),
                .z     (prod_hl)
            );

            vedic_mul_unsigned #(
                .WIDTH(HALF)
            ) u_mul_hh (
                .a     (a[WIDTH-1:HALF]),
                .b     (b[WIDTH-1:HALF]),
                .osize (osize),
                .z     (prod_hh)
            );

            always_comb begin
                case (osize)
                    OSIZE_8:  elem_bits = `RV_BYTE_WIDTH;
                    OSIZE_16: elem_bits = 2 * `RV_BYTE_WIDTH;
                    default:  elem_bits = 4 * `RV_BYTE_WIDTH;
                endcase
            end

            // Elements narrower than this level never mix their halves
            assign cross_en = (elem_bits >= WIDTH);
            assign cross_lh = cross_en ? prod_lh : '0;
            assign cross_hl = cross_en ? prod_hl : '0;

            assign cross_sum = {{WIDTH{1'b0}}, cross_lh} + {{WIDTH{1'b0}}, cross_hl};
            assign z = {prod_hh, prod_ll} + (cross_sum << HALF);
        end
    endgenerate

endmodule : vedic_mul_unsigned

/* riscv_v_twos_comp_sel.sv */
/*
 * Per-element conditional two's complement over one lane
 * Element size chosen at run time, flags per byte position
 */

`timescale 1ns/1ps

`include "riscv_v_consts.svh"

module riscv_v_twos_comp_sel
    import riscv_v_pkg::*;
#(
    parameter int BLOCK_WIDTH = 8,
    localparam int NUM_BLOCKS = `RV_LANE_WIDTH / `RV_BYTE_WIDTH,
    localparam int IN_WIDTH   = NUM_BLOCKS * BLOCK_WIDTH
) (
    input  logic [IN_WIDTH-1:0]   in,
    input  logic [NUM_BLOCKS-1:0] complement,
    input  osize_e                osize,
    output logic [IN_WIDTH-1:0]   out
);

    // One candidate result for each element size
    logic [IN_WIDTH-1:0] neg_by_size [3];

    generate
        for (genvar size_idx = 0; size_idx < 3; size_idx++) begin : gen_size
            localparam int ELEM_WIDTH = BLOCK_WIDTH << size_idx;
            localparam int NUM_ELEMS  = NUM_BLOCKS >> size_idx;
            localparam int FLAG_STEP  = 1 << size_idx;

            for (genvar elem_idx = 0; elem_idx < NUM_ELEMS; elem_idx++) begin : gen_elem
                logic [ELEM_WIDTH-1:0] elem;

                assign elem = in[elem_idx*ELEM_WIDTH +: ELEM_WIDTH];

                // Flag is read at the element's lowest byte
                assign neg_by_size[size_idx][elem_idx*ELEM_WIDTH +: ELEM_WIDTH] =
                    complement[elem_idx*FLAG_STEP] ? (~elem + 1'b1) : elem;
            end
        end
    endgenerate

    always_comb begin
        case (osize)
            OSIZE_8:  out = neg_by_size[0];
            OSIZE_16: out = neg_by_size[1];
            default:  out = neg_by_size[2];
        endcase
    end

endmodule : riscv_v_twos_comp_sel

/* riscv_v_pkg.sv */
/*
 * Shared types for the vector multiply unit
 * Element size and opcode enums
 */

package riscv_v_pkg;

    // Element size of one operation
    typedef enum logic [1:0] {
        OSIZE_8  = 2'd0,
        OSIZE_16 = 2'd1,
        OSIZE_32 = 2'd2
    } osize_e;

    // Which half of the double-width product is returned
    typedef enum logic {
        MUL_LO = 1'b0,
        MUL_HI = 1'b1
    } mul_op_e;

endpackage : riscv_v_pkg

/* riscv_v_consts.svh */
/*
 * Width constants for the vector multiply datapath
 * Data, lane and byte widths, lane count, vedic recursion floor
 */

`ifndef RISCV_V_CONSTS_SVH
`define RISCV_V_CONSTS_SVH

// Full vector datapath
`define RV_DATA_WIDTH 64

// One multiplier lane
`define RV_LANE_WIDTH 32

// Lanes across the datapath
`define RV_NUM_LANES 2

// Smallest element size
`define RV_BYTE_WIDTH 8

// Vedic recursion stops here and multiplies directly
`define RV_MIN_VEDIC_WIDTH 2

`endif
